/* hw/burst_split_pkg.sv */
/*
  Shared constants for the AXI4 read burst splitter.
  Only FIXED and INCR bursts are handled. WRAP is stepped like FIXED.
  LEN_FIFO_DEPTH must equal 2**LEN_PTR_W so that the pointers wrap on their own.
  BEAT_CNT_W must be at least LEN_W so a full 256-beat burst can be counted.
*/
package burst_split_pkg;

  // ------------------------------------------------------------
  // Bus field widths
  // ------------------------------------------------------------

  // Address and data
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Transaction ID
  localparam int ID_W = 4;

  // AXI len, beats minus one
  localparam int LEN_W = 8;

  // AXI size, log2 of bytes per beat
  localparam int SIZE_W = 3;

  // AXI burst type
  localparam int BURST_W = 2;

  // ------------------------------------------------------------
  // Burst type encodings
  // ------------------------------------------------------------

  // Same address on every beat
  localparam logic [BURST_W-1:0] BURST_FIXED = 2'd0;
  // Address steps by 2**size on every beat
  localparam logic [BURST_W-1:0] BURST_INCR = 2'd1;

  // ------------------------------------------------------------
  // Outstanding burst bookkeeping
  // ------------------------------------------------------------

  // Bursts that may be in flight at once
  localparam int LEN_FIFO_DEPTH = 4;
  localparam int LEN_PTR_W = 2;

  // Returning beat counter in the R path
  localparam int BEAT_CNT_W = LEN_W;

endpackage

/* hw/ar_chan_if.sv */
/*
  One AXI4 AR channel, reduced to the fields the splitter needs.
  The manager drives the request fields and valid, the subordinate drives ready.
  Once valid is high, it and every field hold until the handshake.
*/
`timescale 1ns/1ps

interface ar_chan_if;

  // Request fields
  logic [burst_split_pkg::ADDR_W-1:0]  addr;
  logic [burst_split_pkg::ID_W-1:0]    id;
  logic [burst_split_pkg::LEN_W-1:0]   len;
  logic [burst_split_pkg::SIZE_W-1:0]  size;
  logic [burst_split_pkg::BURST_W-1:0] burst;

  // Handshake
  logic valid;
  logic ready;

  // Side that issues the read
  modport mgr (
    output addr, id, len, size, burst, valid,
    input  ready
  );

  // Side that accepts the read
  modport sub (
    input  addr, id, len, size, burst, valid,
    output ready
  );

endinterface

/* hw/ar_splitter.sv */
/*
  Accepts one AR burst at a time and replays it as len+1 single-beat reads.
  Upstream ready is low while a burst is being split or the length record is full.
  INCR steps the address by 2**size per beat, other burst types repeat it.
  The address step does not respect 4 KiB boundaries; the upstream must.
*/
`timescale 1ns/1ps

module ar_splitter (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  ar_chan_if.sub                            up_ar,
  ar_chan_if.mgr                            dn_ar,
  output logic                              len_push_o,
  output logic [burst_split_pkg::LEN_W-1:0] len_o,
  input  logic                              len_full_i
);

  // ------------------------------------------------------------
  // State
  // ------------------------------------------------------------

  // Idle when low, Busy when high
  logic busy_q;

  // Beats still to send after the current one
  logic [burst_split_pkg::LEN_W-1:0] remain_q;

  // Stored burst, address moves as beats go out
  logic [burst_split_pkg::ADDR_W-1:0]  addr_q;
  logic [burst_split_pkg::ID_W-1:0]    id_q;
  logic [burst_split_pkg::SIZE_W-1:0]  size_q;
  logic [burst_split_pkg::BURST_W-1:0] burst_q;

  logic                               up_hs;
  logic                               dn_hs;
  logic                               last_beat;
  logic [burst_split_pkg::ADDR_W-1:0] addr_step;

  // ------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------

  // Take a new burst only in Idle and only if its length can be recorded
  assign up_ar.ready = ~busy_q & ~len_full_i;
  assign up_hs       = up_ar.valid & up_ar.ready;
  assign dn_hs       = dn_ar.valid & dn_ar.ready;

  // Current beat closes the burst
  assign last_beat = (remain_q == '0);

  // Bytes per beat
  assign addr_step = {{(burst_split_pkg::ADDR_W-1){1'b0}}, 1'b1} << size_q;

  // Record the length in the same cycle as the upstream handshake
  assign len_push_o = up_hs;
  assign len_o      = up_ar.len;

  // ------------------------------------------------------------
  // Idle/Busy FSM and beat counter
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q   <= 1'b0;
      remain_q <= '0;
    end else if (up_hs) begin
      busy_q   <= 1'b1;
      remain_q <= up_ar.len;
    end else if (dn_hs) begin
      // Back to Idle once the final split beat is taken
      if (last_beat) begin
        busy_q <= 1'b0;
      end else begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  // Capture on accept, step the address on each accepted beat
  always_ff @(posedge clk_i) begin
    if (up_hs) begin
      addr_q  <= up_ar.addr;
      id_q    <= up_ar.id;
      size_q  <= up_ar.size;
      burst_q <= up_ar.burst;
    end else if (dn_hs && (burst_q == burst_split_pkg::BURST_INCR)) begin
      addr_q <= addr_q + addr_step;
    end
  end

  // ------------------------------------------------------------
  // Downstream single-beat request
  // ------------------------------------------------------------
  assign dn_ar.valid = busy_q;
  assign dn_ar.addr  = addr_q;
  assign dn_ar.id    = id_q;
  assign dn_ar.size  = size_q;
  assign dn_ar.burst = burst_q;
  // Every split read is one beat
  assign dn_ar.len   = '0;

endmodule

/* hw/burst_len_fifo.sv */
/*
  In-order record of the len field of every outstanding burst.
  Depth is LEN_FIFO_DEPTH and must be a power of two matching LEN_PTR_W.
  A push while full and a pop while empty are ignored.
  The head entry is shown combinationally from the storage array.
*/
`timescale 1ns/1ps

module burst_len_fifo (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              push_i,
  input  logic [burst_split_pkg::LEN_W-1:0] len_i,
  output logic                              full_o,
  input  logic                              pop_i,
  output logic [burst_split_pkg::LEN_W-1:0] head_len_o,
  output logic                              empty_o
);

  // Storage, one len per outstanding burst
  logic [burst_split_pkg::LEN_W-1:0] mem_q [burst_split_pkg::LEN_FIFO_DEPTH];

  logic [burst_split_pkg::LEN_PTR_W-1:0] wr_ptr_q;
  logic [burst_split_pkg::LEN_PTR_W-1:0] rd_ptr_q;

  // One extra bit so that full and empty differ
  logic [burst_split_pkg::LEN_PTR_W:0] count_q;

  logic push_ok;
  logic pop_ok;

  // ------------------------------------------------------------
  // Status
  // ------------------------------------------------------------
  assign full_o  = (count_q == (burst_split_pkg::LEN_PTR_W+1)'(burst_split_pkg::LEN_FIFO_DEPTH));
  assign empty_o = (count_q == '0);

  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  // Oldest burst still returning data
  assign head_len_o = mem_q[rd_ptr_q];

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap naturally at the power-of-two depth
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Write side
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= len_i;
    end
  end

endmodule

/* hw/r_last_restore.sv */
/*
  Passes single-beat R responses upstream and rebuilds last per burst.
  Responses must come back in request order, since the head length
  of the record is taken to belong to the beat now returning.
  Both handshakes are blocked while no burst is recorded.
*/
`timescale 1ns/1ps

module r_last_restore (
  input  logic                              clk_i,
  input  logic                              arst_n_i,

  // Downstream side, single beats
  input  logic [burst_split_pkg::DATA_W-1:0] dn_r_data_i,
  input  logic [burst_split_pkg::ID_W-1:0]   dn_r_id_i,
  input  logic [1:0]                         dn_r_resp_i,
  input  logic                               dn_r_valid_i,
  output logic                               dn_r_ready_o,

  // Upstream side, rebuilt bursts
  output logic [burst_split_pkg::DATA_W-1:0] up_r_data_o,
  output logic [burst_split_pkg::ID_W-1:0]   up_r_id_o,
  output logic [1:0]                         up_r_resp_o,
  output logic                               up_r_valid_o,
  output logic                               up_r_last_o,
  input  logic                               up_r_ready_i,

  // Length record
  input  logic [burst_split_pkg::LEN_W-1:0] head_len_i,
  input  logic                              empty_i,
  output logic                              pop_o
);

  // Beats of the head burst already delivered
  logic [burst_split_pkg::BEAT_CNT_W-1:0] beat_cnt_q;

  logic up_hs;

  // ------------------------------------------------------------
  // Pass-through with gated handshake
  // ------------------------------------------------------------

  // Payload goes straight through
  assign up_r_data_o = dn_r_data_i;
  assign up_r_id_o   = dn_r_id_i;
  assign up_r_resp_o = dn_r_resp_i;

  // A beat with no recorded burst is held back
  assign up_r_valid_o = dn_r_valid_i & ~empty_i;
  assign dn_r_ready_o = up_r_ready_i & ~empty_i;

  assign up_hs = up_r_valid_o & up_r_ready_i;

  // Final beat once the count reaches len of the head burst
  assign up_r_last_o = (beat_cnt_q == burst_split_pkg::BEAT_CNT_W'(head_len_i));

  // Retire the head record with the last beat
  assign pop_o = up_hs & up_r_last_o;

  // ------------------------------------------------------------
  // Beat counter
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
    end else if (up_hs) begin
      if (up_r_last_o) begin
        // Next beat starts a new burst
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

/* hw/burst_split_top.sv */
/*
  AXI4 read burst splitter, top level with plain AR and R ports.
  Upstream bursts leave as single-beat reads. R last is rebuilt.
  Downstream must answer in request order, out-of-order IDs are not supported.
  At most LEN_FIFO_DEPTH bursts are outstanding before s_ar_ready_o drops.
*/
`timescale 1ns/1ps

module burst_split_top (
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  // Upstream AR
  input  logic [burst_split_pkg::ADDR_W-1:0]  s_ar_addr_i,
  input  logic [burst_split_pkg::ID_W-1:0]    s_ar_id_i,
  input  logic [burst_split_pkg::LEN_W-1:0]   s_ar_len_i,
  input  logic [burst_split_pkg::SIZE_W-1:0]  s_ar_size_i,
  input  logic [burst_split_pkg::BURST_W-1:0] s_ar_burst_i,
  input  logic                                s_ar_valid_i,
  output logic                                s_ar_ready_o,

  // Downstream AR, single beats
  output logic [burst_split_pkg::ADDR_W-1:0]  m_ar_addr_o,
  output logic [burst_split_pkg::ID_W-1:0]    m_ar_id_o,
  output logic [burst_split_pkg::LEN_W-1:0]   m_ar_len_o,
  output logic [burst_split_pkg::SIZE_W-1:0]  m_ar_size_o,
  output logic [burst_split_pkg::BURST_W-1:0] m_ar_burst_o,
  output logic                                m_ar_valid_o,
  input  logic                                m_ar_ready_i,

  // Downstream R
  input  logic [burst_split_pkg::DATA_W-1:0]  m_r_data_i,
  input  logic [burst_split_pkg::ID_W-1:0]    m_r_id_i,
  input  logic [1:0]                          m_r_resp_i,
  input  logic                                m_r_valid_i,
  output logic                                m_r_ready_o,

  // Upstream R
  output logic [burst_split_pkg::DATA_W-1:0]  s_r_data_o,
  output logic [burst_split_pkg::ID_W-1:0]    s_r_id_o,
  output logic [1:0]                          s_r_resp_o,
  output logic                                s_r_last_o,
  output logic                                s_r_valid_o,
  input  logic                                s_r_ready_i
);

  // ------------------------------------------------------------
  // AR channels
  // ------------------------------------------------------------
  ar_chan_if up_ar ();
  ar_chan_if dn_ar ();

  // Upstream ports into the splitter
  assign up_ar.addr   = s_ar_addr_i;
  assign up_ar.id     = s_ar_id_i;
  assign up_ar.len    = s_ar_len_i;
  assign up_ar.size   = s_ar_size_i;
  assign up_ar.burst  = s_ar_burst_i;
  assign up_ar.valid  = s_ar_valid_i;
  assign s_ar_ready_o = up_ar.ready;

  // Split beats out to the ports
  assign m_ar_addr_o  = dn_ar.addr;
  assign m_ar_id_o    = dn_ar.id;
  assign m_ar_len_o   = dn_ar.len;
  assign m_ar_size_o  = dn_ar.size;
  assign m_ar_burst_o = dn_ar.burst;
  assign m_ar_valid_o = dn_ar.valid;
  assign dn_ar.ready  = m_ar_ready_i;

  // Length record links
  logic                              len_push;
  logic [burst_split_pkg::LEN_W-1:0] len_rec;
  logic                              len_full;
  logic [burst_split_pkg::LEN_W-1:0] head_len;
  logic                              len_empty;
  logic                              len_pop;

  // ------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------
  ar_splitter ar_splitter_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .up_ar      (up_ar),
    .dn_ar      (dn_ar),
    .len_push_o (len_push),
    .len_o      (len_rec),
    .len_full_i (len_full)
  );

  burst_len_fifo burst_len_fifo_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .push_i     (len_push),
    .len_i      (len_rec),
    .full_o     (len_full),
    .pop_i      (len_pop),
    .head_len_o (head_len),
    .empty_o    (len_empty)
  );

  r_last_restore r_last_restore_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dn_r_data_i  (m_r_data_i),
    .dn_r_id_i    (m_r_id_i),
    .dn_r_resp_i  (m_r_resp_i),
    .dn_r_valid_i (m_r_valid_i),
    .dn_r_ready_o (m_r_ready_o),
    .up_r_data_o  (s_r_data_o),
    .up_r_id_o    (s_r_id_o),
    .up_r_resp_o  (s_r_resp_o),
    .up_r_valid_o (s_r_valid_o),
    .up_r_last_o  (s_r_last_o),
    .up_r_ready_i (s_r_ready_i),
    .head_len_i   (head_len),
    .empty_i      (len_empty),
    .pop_o        (len_pop)
  );

endmodule

/* test/rd_responder.sv */
/*
  Downstream memory model for single-beat AXI4 reads.
  Reads are answered strictly in order, with data equal to the read address.
  AR ready and the gap between responses are random from a fixed seed.
  While stall_i is high no new response is started.
*/
`timescale 1ns/1ps

module rd_responder #(
  parameter logic [31:0] SEED = 32'ha2a4
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [burst_split_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic [burst_split_pkg::ID_W-1:0]   ar_id_i,
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  output logic [burst_split_pkg::DATA_W-1:0] r_data_o,
  output logic [burst_split_pkg::ID_W-1:0]   r_id_o,
  output logic [1:0]                         r_resp_o,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  input  logic                               stall_i
);

  integer seed;

  // Accepted reads waiting for their response
  logic [burst_split_pkg::ADDR_W-1:0] addr_q [$];
  logic [burst_split_pkg::ID_W-1:0]   id_q [$];

  // Idle cycles left before the next response
  int gap;

  initial seed = SEED;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      r_id_o     <= '0;
      r_resp_o   <= 2'b00;
      gap = 0;
      addr_q.delete();
      id_q.delete();
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        addr_q.push_back(ar_addr_i);
        id_q.push_back(ar_id_i);
      end
      // Roughly three reads in four are accepted at once
      ar_ready_o <= ($unsigned($random(seed)) % 4) != 0;

      if (r_valid_o && !r_ready_i) begin
        // Beat held until taken
      end else if (gap > 0) begin
        r_valid_o <= 1'b0;
        gap = gap - 1;
      end else if (addr_q.size() > 0 && !stall_i) begin
        r_valid_o <= 1'b1;
        r_data_o  <= burst_split_pkg::DATA_W'(addr_q.pop_front());
        r_id_o    <= id_q.pop_front();
        r_resp_o  <= 2'b00;
        gap = int'($unsigned($random(seed)) % 3);
      end else begin
        r_valid_o <= 1'b0;
      end
    end
  end

endmodule

/* test/tb_burst_split.sv */
/*
  Testbench for the AXI4 read burst splitter.
  Random FIXED or INCR bursts, len 0..15 and size 0..2, from a fixed seed.
  Expected split addresses and read data follow base + k * 2**size.
  A second phase stalls the response path to fill the length record.
*/
`timescale 1ns/1ps

module tb_burst_split;

  localparam int NUM_BURSTS  = 30;
  localparam int FILL_BURSTS = burst_split_pkg::LEN_FIFO_DEPTH + 1;
  localparam int WAIT_LIMIT  = 3000;
  localparam int HOLD_CYCLES = 60;
  localparam int DEPTH       = burst_split_pkg::LEN_FIFO_DEPTH;

  logic        clk_i;
  logic        arst_n_i;
  logic [31:0] s_ar_addr_i;
  logic [3:0]  s_ar_id_i;
  logic [7:0]  s_ar_len_i;
  logic [2:0]  s_ar_size_i;
  logic [1:0]  s_ar_burst_i;
  logic        s_ar_valid_i;
  logic        s_ar_ready_o;
  logic [31:0] m_ar_addr_o;
  logic [3:0]  m_ar_id_o;
  logic [7:0]  m_ar_len_o;
  logic [2:0]  m_ar_size_o;
  logic [1:0]  m_ar_burst_o;
  logic        m_ar_valid_o;
  logic        m_ar_ready_i;
  logic [31:0] m_r_data_i;
  logic [3:0]  m_r_id_i;
  logic [1:0]  m_r_resp_i;
  logic        m_r_valid_i;
  logic        m_r_ready_o;
  logic [31:0] s_r_data_o;
  logic [3:0]  s_r_id_o;
  logic [1:0]  s_r_resp_o;
  logic        s_r_last_o;
  logic        s_r_valid_o;
  logic        s_r_ready_i;
  logic        stall;
  integer      seed;

  // Generated stimulus, then bursts as seen on the upstream handshake
  logic [31:0] gen_addr [NUM_BURSTS];
  logic [3:0]  gen_id [NUM_BURSTS];
  logic [7:0]  gen_len [NUM_BURSTS];
  logic [2:0]  gen_size [NUM_BURSTS];
  logic [1:0]  gen_burst [NUM_BURSTS];
  logic [31:0] acc_addr [NUM_BURSTS];
  logic [3:0]  acc_id [NUM_BURSTS];
  logic [7:0]  acc_len [NUM_BURSTS];
  logic [2:0]  acc_size [NUM_BURSTS];
  logic [1:0]  acc_burst [NUM_BURSTS];

  // Burst and beat position on each side
  int acc_cnt = 0;
  int ar_idx = 0;
  int ar_beat = 0;
  int r_idx = 0;
  int r_beat = 0;
  int err_cnt = 0;
  int check_cnt = 0;
  logic abort = 1'b0;

  // Previous-edge samples for the reset and hold checks
  logic rst_prev = 1'b0;
  logic r_hold_prev = 1'b0;
  logic ar_hold_prev = 1'b0;
  logic [31:0] r_data_prev;
  logic [3:0]  r_id_prev;
  logic        r_last_prev;
  logic [31:0] ar_addr_prev;
  logic [3:0]  ar_id_prev;
  logic [7:0]  ar_len_prev;
  logic [2:0]  ar_size_prev;
  logic [1:0]  ar_burst_prev;

  burst_split_top burst_split_top_i (.*);

  rd_responder #(.SEED(32'ha2a4)) rd_responder_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .ar_addr_i(m_ar_addr_o), .ar_id_i(m_ar_id_o), .ar_valid_i(m_ar_valid_o),
    .ar_ready_o(m_ar_ready_i), .r_data_o(m_r_data_i), .r_id_o(m_r_id_i),
    .r_resp_o(m_r_resp_i), .r_valid_o(m_r_valid_i), .r_ready_i(m_r_ready_o),
    .stall_i(stall)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Address of beat k, FIXED repeats the base
  function automatic logic [31:0] beat_addr(input logic [31:0] base, input logic [2:0] size,
                                            input logic [1:0] burst, input int k);
    if (burst == burst_split_pkg::BURST_INCR) begin
      return base + (32'(k) << size);
    end
    return base;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  // ------------------------------------------------------------
  // Monitor and scoreboard
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!arst_n_i || !rst_prev) begin
      check_eq("m_ar_valid_o", 32'(m_ar_valid_o), 32'd0);
      check_eq("s_r_valid_o", 32'(s_r_valid_o), 32'd0);
    end
    rst_prev = arst_n_i;
    if (arst_n_i) begin
      // Payload held under back-pressure
      if (r_hold_prev) begin
        check_eq("s_r_data_o", s_r_data_o, r_data_prev);
        check_eq("s_r_id_o", 32'(s_r_id_o), 32'(r_id_prev));
        check_eq("s_r_last_o", 32'(s_r_last_o), 32'(r_last_prev));
      end
      if (ar_hold_prev) begin
        check_eq("m_ar_valid_o", 32'(m_ar_valid_o), 32'd1);
        check_eq("m_ar_addr_o", m_ar_addr_o, ar_addr_prev);
        check_eq("m_ar_id_o", 32'(m_ar_id_o), 32'(ar_id_prev));
        check_eq("m_ar_len_o", 32'(m_ar_len_o), 32'(ar_len_prev));
        check_eq("m_ar_size_o", 32'(m_ar_size_o), 32'(ar_size_prev));
        check_eq("m_ar_burst_o", 32'(m_ar_burst_o), 32'(ar_burst_prev));
      end
      // Outstanding bursts bounded by the record depth
      check_true(acc_cnt - r_idx <= DEPTH, "more bursts outstanding than the record can hold");
      if (acc_cnt - r_idx == DEPTH) begin
        check_eq("s_ar_ready_o", 32'(s_ar_ready_o), 32'd0);
      end
      // Downstream R ready follows upstream ready only while a burst is outstanding
      check_eq("m_r_ready_o", 32'(m_r_ready_o),
               32'(s_r_ready_i && (acc_cnt != r_idx)));
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (ar_idx >= acc_cnt) begin
          check_true(1'b0, "split read issued with no burst pending");
        end else begin
          check_eq("m_ar_len_o", 32'(m_ar_len_o), 32'd0);
          check_eq("m_ar_id_o", 32'(m_ar_id_o), 32'(acc_id[ar_idx]));
          check_eq("m_ar_size_o", 32'(m_ar_size_o), 32'(acc_size[ar_idx]));
          check_eq("m_ar_burst_o", 32'(m_ar_burst_o), 32'(acc_burst[ar_idx]));
          check_eq("m_ar_addr_o", m_ar_addr_o,
                   beat_addr(acc_addr[ar_idx], acc_size[ar_idx], acc_burst[ar_idx], ar_beat));
          if (ar_beat == int'(acc_len[ar_idx])) begin
            ar_idx++;
            ar_beat = 0;
          end else begin
            ar_beat++;
          end
        end
      end
      if (s_r_valid_o && s_r_ready_i) begin
        if (r_idx >= acc_cnt) begin
          check_true(1'b0, "read data returned with no burst pending");
        end else begin
          check_eq("s_r_data_o", s_r_data_o,
                   beat_addr(acc_addr[r_idx], acc_size[r_idx], acc_burst[r_idx], r_beat));
          check_eq("s_r_id_o", 32'(s_r_id_o), 32'(acc_id[r_idx]));
          check_eq("s_r_resp_o", 32'(s_r_resp_o), 32'd0);
          check_eq("s_r_last_o", 32'(s_r_last_o), 32'(r_beat == int'(acc_len[r_idx])));
          if (r_beat == int'(acc_len[r_idx])) begin
            r_idx++;
            r_beat = 0;
          end else begin
            r_beat++;
          end
        end
      end
      if (s_ar_valid_i && s_ar_ready_o) begin
        check_true(acc_cnt < NUM_BURSTS, "more bursts accepted than were sent");
        if (acc_cnt < NUM_BURSTS) begin
          acc_addr[acc_cnt]  = s_ar_addr_i;
          acc_id[acc_cnt]    = s_ar_id_i;
          acc_len[acc_cnt]   = s_ar_len_i;
          acc_size[acc_cnt]  = s_ar_size_i;
          acc_burst[acc_cnt] = s_ar_burst_i;
          acc_cnt++;
        end
      end
    end
    r_hold_prev   = arst_n_i && s_r_valid_o && !s_r_ready_i;
    r_data_prev   = s_r_data_o;
    r_id_prev     = s_r_id_o;
    r_last_prev   = s_r_last_o;
    ar_hold_prev  = arst_n_i && m_ar_valid_o && !m_ar_ready_i;
    ar_addr_prev  = m_ar_addr_o;
    ar_id_prev    = m_ar_id_o;
    ar_len_prev   = m_ar_len_o;
    ar_size_prev  = m_ar_size_o;
    ar_burst_prev = m_ar_burst_o;
  end

  // Random upstream R back-pressure
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      s_r_ready_i <= ($unsigned($random(seed)) % 3) != 0;
    end
  end

  // ------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------
  task automatic start_burst(input int idx);
    s_ar_addr_i  <= gen_addr[idx];
    s_ar_id_i    <= gen_id[idx];
    s_ar_len_i   <= gen_len[idx];
    s_ar_size_i  <= gen_size[idx];
    s_ar_burst_i <= gen_burst[idx];
    s_ar_valid_i <= 1'b1;
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!s_ar_ready_o && cycles < WAIT_LIMIT);
    if (s_ar_ready_o) begin
      s_ar_valid_i <= 1'b0;
    end else begin
      err_cnt++;
      abort = 1'b1;
      $display("Error at %0t ns: upstream AR was not accepted in time", $time);
    end
  endtask

  // Until every accepted burst is split and returned
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    if (!abort) begin
      do begin
        @(posedge clk_i);
        cycles++;
      end while ((ar_idx != acc_cnt || r_idx != acc_cnt) && cycles < WAIT_LIMIT);
      if (ar_idx != acc_cnt || r_idx != acc_cnt) begin
        err_cnt++;
        abort = 1'b1;
        $display("Error at %0t ns: outstanding bursts did not complete in time", $time);
      end
    end
  endtask

  task automatic print_summary();
    $display("checks %0d, errors %0d, bursts accepted %0d", check_cnt, err_cnt, acc_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    seed         = 32'ha2a4;
    arst_n_i     = 1'b1;
    s_ar_addr_i  = '0;
    s_ar_id_i    = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = '0;
    s_ar_valid_i = 1'b0;
    s_r_ready_i  = 1'b0;
    stall        = 1'b0;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      gen_addr[i]  = $random(seed);
      gen_id[i]    = 4'($unsigned($random(seed)) % 16);
      gen_len[i]   = 8'($unsigned($random(seed)) % 16);
      gen_size[i]  = 3'($unsigned($random(seed)) % 3);
      gen_burst[i] = (($random(seed) & 1) != 0) ? burst_split_pkg::BURST_INCR
                                                : burst_split_pkg::BURST_FIXED;
    end
    // Falling edge before the first clock so the asynchronous reset fires
    #1 arst_n_i = 1'b0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Free-running traffic
    for (int i = 0; i < NUM_BURSTS - FILL_BURSTS && !abort; i++) begin
      start_burst(i);
      wait_accept();
    end
    wait_drain();

    // Return path stalled, record fills and the last burst must wait
    if (!abort) begin
      stall <= 1'b1;
      for (int i = NUM_BURSTS - FILL_BURSTS; i < NUM_BURSTS - 1 && !abort; i++) begin
        start_burst(i);
        wait_accept();
      end
      if (!abort) begin
        start_burst(NUM_BURSTS - 1);
        repeat (HOLD_CYCLES) @(posedge clk_i);
        stall <= 1'b0;
        wait_accept();
      end
      wait_drain();
    end
    print_summary();
  end

endmodule

/* filelist.f */
hw/burst_split_pkg.sv
hw/ar_chan_if.sv
hw/ar_splitter.sv
hw/burst_len_fifo.sv
hw/r_last_restore.sv
hw/burst_split_top.sv
test/rd_responder.sv
test/tb_burst_split.sv

/* Makefile */
# Verilator build and run for the AXI4 read burst splitter

VERILATOR ?= verilator
TOP       ?= tb_burst_split
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
